// ==== Makefile ====
# Verilator simulation of the load queue testbench
# Override any variable on the command line, for example make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_load_queue
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/load_queue.sv ====
// Load queue with miss replay in slot order (not age order) and store mis-speculation flags
// Each ROB tag is expected to sit in at most one non-empty slot at a time
`timescale 1ns/10ps

module load_queue (
    input  logic                                    clk,
    input  logic                                    n_rst,
    input  logic                                    i_flush,
    output logic                                    o_full,
    input  logic                                    i_alloc_en,
    input  lsu_op_pkg::lsu_op_t                     i_alloc_op,
    input  logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0]    i_alloc_tag,
    input  logic [lsu_op_pkg::ADDR_WIDTH-1:0]       i_alloc_addr,
    output logic [lq_cfg_pkg::LQ_DEPTH-1:0]         o_alloc_select,
    input  logic                                    i_replay_stall,
    output logic                                    o_replay_en,
    output logic [lq_cfg_pkg::LQ_DEPTH-1:0]         o_replay_select,
    output lsu_op_pkg::lsu_op_t                     o_replay_op,
    output logic [lsu_op_pkg::ADDR_WIDTH-1:0]       o_replay_addr,
    output logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0]    o_replay_tag,
    input  logic                                    i_update_en,
    input  logic [lq_cfg_pkg::LQ_DEPTH-1:0]         i_update_select,
    input  logic                                    i_update_retry,
    input  logic [lq_cfg_pkg::MHQ_TAG_WIDTH-1:0]    i_update_mhq_tag,
    input  logic                                    i_update_mhq_retry,
    input  logic                                    i_mhq_fill_en,
    input  logic [lq_cfg_pkg::MHQ_TAG_WIDTH-1:0]    i_mhq_fill_tag,
    input  logic                                    i_store_retire_en,
    input  logic [lsu_op_pkg::ADDR_WIDTH-1:0]       i_store_retire_addr,
    input  lsu_op_pkg::lsu_op_t                     i_store_retire_op,
    input  logic                                    i_rob_retire_en,
    input  logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0]    i_rob_retire_tag,
    output logic                                    o_rob_retire_ack,
    output logic                                    o_rob_retire_misspec
);

    // Per-slot payload, written only on allocation or update
    logic [lsu_op_pkg::ADDR_WIDTH-1:0]      addr_q    [lq_cfg_pkg::LQ_DEPTH];
    logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0]   tag_q     [lq_cfg_pkg::LQ_DEPTH];
    lsu_op_pkg::lsu_op_t                    op_q      [lq_cfg_pkg::LQ_DEPTH];
    logic [lq_cfg_pkg::MHQ_TAG_WIDTH-1:0]   mhq_tag_q [lq_cfg_pkg::LQ_DEPTH];
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        misspec_q;
    lq_cfg_pkg::lq_state_t                  state_q    [lq_cfg_pkg::LQ_DEPTH];
    lq_cfg_pkg::lq_state_t                  state_next [lq_cfg_pkg::LQ_DEPTH];

    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        empty;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        replayable;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        waiting;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        update_sel;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        fill_match;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        retire_sel;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        store_hit;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        alloc_sel;
    logic [lq_cfg_pkg::LQ_IDX_WIDTH-1:0]    alloc_idx;
    logic                                   alloc_any;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]        replay_sel;
    logic [lq_cfg_pkg::LQ_IDX_WIDTH-1:0]    replay_idx;
    logic                                   replay_any;
    logic [lq_cfg_pkg::LQ_IDX_WIDTH-1:0]    retire_idx;
    logic                                   retire_ack;
    lq_cfg_pkg::lq_state_t                  update_state;

    // Per-slot status decode
    always_comb begin
        for (int i = 0; i < lq_cfg_pkg::LQ_DEPTH; i++) begin
            empty[i]      = (state_q[i] == lq_cfg_pkg::LQ_EMPTY);
            replayable[i] = (state_q[i] == lq_cfg_pkg::LQ_REPLAYABLE);
            // A load still waiting on the cache has not produced data yet
            waiting[i]    = (state_q[i] == lq_cfg_pkg::LQ_TAG_WAIT) ||
                            (state_q[i] == lq_cfg_pkg::LQ_FILL_WAIT) ||
                            (state_q[i] == lq_cfg_pkg::LQ_REPLAYABLE);
            update_sel[i] = i_update_en & i_update_select[i];
            fill_match[i] = i_mhq_fill_en & (mhq_tag_q[i] == i_mhq_fill_tag);
            retire_sel[i] = i_rob_retire_en & !empty[i] & (tag_q[i] == i_rob_retire_tag);
        end
    end

    // New loads take the lowest empty slot
    lq_pick_first #(
        .WIDTH (lq_cfg_pkg::LQ_DEPTH)
    ) u_alloc_pick (
        .i_req    (empty & {lq_cfg_pkg::LQ_DEPTH{i_alloc_en}}),
        .o_onehot (alloc_sel),
        .o_idx    (alloc_idx),
        .o_any    (alloc_any)
    );

    // A stall holds every replayable slot where it is
    lq_pick_first #(
        .WIDTH (lq_cfg_pkg::LQ_DEPTH)
    ) u_replay_pick (
        .i_req    (replayable & {lq_cfg_pkg::LQ_DEPTH{~i_replay_stall}}),
        .o_onehot (replay_sel),
        .o_idx    (replay_idx),
        .o_any    (replay_any)
    );

    lq_store_overlap u_store_overlap (
        .i_store_en   (i_store_retire_en),
        .i_store_addr (i_store_retire_addr),
        .i_store_op   (i_store_retire_op),
        .i_load_addr  (addr_q),
        .i_load_op    (op_q),
        .o_hit        (store_hit)
    );

    // Full as seen after this cycle's allocation has landed
    assign o_full = ((empty & ~alloc_sel) == '0);

    // Only one slot matches the retire tag, so a plain encode is enough
    always_comb begin
        retire_idx = '0;
        for (int i = 0; i < lq_cfg_pkg::LQ_DEPTH; i++) begin
            if (retire_sel[i]) begin
                retire_idx = lq_cfg_pkg::LQ_IDX_WIDTH'(i);
            end
        end
    end

    assign retire_ack = (|retire_sel) && (state_q[retire_idx] == lq_cfg_pkg::LQ_DONE);

    // Outcome of an execute result, shared by every slot it selects
    // A fill for the same tag in the same cycle skips the wait altogether
    always_comb begin
        if (!i_update_retry) begin
            update_state = lq_cfg_pkg::LQ_DONE;
        end else if (i_update_mhq_retry) begin
            update_state = lq_cfg_pkg::LQ_FILL_WAIT;
        end else if (i_mhq_fill_en && (i_update_mhq_tag == i_mhq_fill_tag)) begin
            update_state = lq_cfg_pkg::LQ_REPLAYABLE;
        end else begin
            update_state = lq_cfg_pkg::LQ_TAG_WAIT;
        end
    end

    // Slot FSMs, a retire frees any occupied slot ahead of other events
    always_comb begin
        for (int i = 0; i < lq_cfg_pkg::LQ_DEPTH; i++) begin
            state_next[i] = state_q[i];
            if (retire_sel[i]) begin
                state_next[i] = lq_cfg_pkg::LQ_EMPTY;
            end else begin
                case (state_q[i])
                    lq_cfg_pkg::LQ_EMPTY: begin
                        if (alloc_sel[i]) state_next[i] = lq_cfg_pkg::LQ_ISSUED;
                    end
                    lq_cfg_pkg::LQ_ISSUED,
                    lq_cfg_pkg::LQ_LAUNCHED: begin
                        if (update_sel[i]) state_next[i] = update_state;
                    end
                    lq_cfg_pkg::LQ_TAG_WAIT: begin
                        if (fill_match[i]) state_next[i] = lq_cfg_pkg::LQ_REPLAYABLE;
                    end
                    lq_cfg_pkg::LQ_FILL_WAIT: begin
                        // Any fill frees a line, so the load tries again
                        if (i_mhq_fill_en) state_next[i] = lq_cfg_pkg::LQ_REPLAYABLE;
                    end
                    lq_cfg_pkg::LQ_REPLAYABLE: begin
                        if (replay_sel[i]) state_next[i] = lq_cfg_pkg::LQ_LAUNCHED;
                    end
                    lq_cfg_pkg::LQ_DONE: begin
                        state_next[i] = lq_cfg_pkg::LQ_DONE;
                    end
                    default: state_next[i] = lq_cfg_pkg::LQ_EMPTY;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lq_cfg_pkg::LQ_DEPTH; i++) begin
            if (!n_rst || i_flush) begin
                state_q[i] <= lq_cfg_pkg::LQ_EMPTY;
            end else begin
                state_q[i] <= state_next[i];
            end
        end
    end

    // The flag only sticks once the load may have handed out data
    // A waiting load will read memory again after the store anyway
    always_ff @(posedge clk) begin
        for (int i = 0; i < lq_cfg_pkg::LQ_DEPTH; i++) begin
            misspec_q[i] <= !(alloc_sel[i] | waiting[i]) & (store_hit[i] | misspec_q[i]);
            if (update_sel[i]) begin
                mhq_tag_q[i] <= i_update_mhq_tag;
            end
        end
    end

    // Payload of the newly allocated load
    always_ff @(posedge clk) begin
        if (alloc_any) begin
            addr_q[alloc_idx] <= i_alloc_addr;
            tag_q[alloc_idx]  <= i_alloc_tag;
            op_q[alloc_idx]   <= i_alloc_op;
        end
    end

    // Responses come back one cycle after the request
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            o_alloc_select <= '0;
        end else begin
            o_alloc_select <= alloc_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= retire_ack;
        end
        // Flag as it stood before this retire
        o_rob_retire_misspec <= misspec_q[retire_idx];
    end

    // Replay outputs freeze while the execute stage stalls
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            o_replay_en <= 1'b0;
        end else if (!i_replay_stall) begin
            o_replay_en <= replay_any;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_replay_stall) begin
            o_replay_select <= replay_sel;
            o_replay_op     <= op_q[replay_idx];
            o_replay_addr   <= addr_q[replay_idx];
            o_replay_tag    <= tag_q[replay_idx];
        end
    end

endmodule

// ==== logic/lq_cfg_pkg.sv ====
// Load queue sizing and slot states
// LQ_DEPTH should stay a power of two so the slot index covers every slot exactly
package lq_cfg_pkg;

    // Number of load slots
    localparam int LQ_DEPTH = 8;

    // Width of a binary slot index
    localparam int LQ_IDX_WIDTH = $clog2(LQ_DEPTH);

    // Reorder buffer tag, used to find the slot at retire
    localparam int ROB_TAG_WIDTH = 5;

    // Miss-handling queue entry tag a missed load waits on
    localparam int MHQ_TAG_WIDTH = 2;

    // EMPTY holds nothing, ISSUED is in the cache pipeline for the first time
    // TAG_WAIT waits for one miss entry, FILL_WAIT for any fill at all
    // LAUNCHED is a replay in flight and DONE waits only for retire
    typedef enum logic [2:0] {
        LQ_EMPTY      = 3'd0,
        LQ_ISSUED     = 3'd1,
        LQ_TAG_WAIT   = 3'd2,
        LQ_FILL_WAIT  = 3'd3,
        LQ_REPLAYABLE = 3'd4,
        LQ_LAUNCHED   = 3'd5,
        LQ_DONE       = 3'd6
    } lq_state_t;

endpackage

// ==== logic/lq_pick_first.sv ====
// Lowest-index priority selector, purely combinational
// With no request set, o_onehot is zero, o_idx is zero and o_any is low
`timescale 1ns/10ps

module lq_pick_first #(
    parameter  int WIDTH     = 8,
    localparam int IDX_WIDTH = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0]     i_req,
    output logic [WIDTH-1:0]     o_onehot,
    output logic [IDX_WIDTH-1:0] o_idx,
    output logic                 o_any
);

    // Subtracting one flips every bit up to and including the lowest set bit
    // Masking with the original vector keeps just that bit
    assign o_onehot = i_req & ~(i_req - WIDTH'(1));

    assign o_any = |i_req;

    // Binary encode of the one-hot result
    always_comb begin
        o_idx = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (o_onehot[i]) begin
                o_idx = IDX_WIDTH'(i);
            end
        end
    end

endmodule

// ==== logic/lq_store_overlap.sv ====
// Byte-range overlap of one retiring store against every load slot
// Ranges that wrap past the top of the address space are not detected
`timescale 1ns/10ps

module lq_store_overlap (
    input  logic                                i_store_en,
    input  logic [lsu_op_pkg::ADDR_WIDTH-1:0]   i_store_addr,
    input  lsu_op_pkg::lsu_op_t                 i_store_op,
    input  logic [lsu_op_pkg::ADDR_WIDTH-1:0]   i_load_addr [lq_cfg_pkg::LQ_DEPTH],
    input  lsu_op_pkg::lsu_op_t                 i_load_op [lq_cfg_pkg::LQ_DEPTH],
    output logic [lq_cfg_pkg::LQ_DEPTH-1:0]     o_hit
);

    logic [lsu_op_pkg::ADDR_WIDTH-1:0] store_end;
    logic [lsu_op_pkg::ADDR_WIDTH-1:0] load_end [lq_cfg_pkg::LQ_DEPTH];
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]   load_in_store;
    logic [lq_cfg_pkg::LQ_DEPTH-1:0]   store_in_load;

    // Access size in bytes, already at address width so it adds directly
    // Anything not byte or half counts as a word
    function automatic logic [lsu_op_pkg::ADDR_WIDTH-1:0] op_size(
        input lsu_op_pkg::lsu_op_t op
    );
        case (op)
            lsu_op_pkg::LSU_OP_LB,
            lsu_op_pkg::LSU_OP_LBU,
            lsu_op_pkg::LSU_OP_SB:  op_size = 1;
            lsu_op_pkg::LSU_OP_LH,
            lsu_op_pkg::LSU_OP_LHU,
            lsu_op_pkg::LSU_OP_SH:  op_size = 2;
            default:                op_size = 4;
        endcase
    endfunction

    // End addresses are exclusive
    assign store_end = i_store_addr + op_size(i_store_op);

    always_comb begin
        for (int i = 0; i < lq_cfg_pkg::LQ_DEPTH; i++) begin
            load_end[i] = i_load_addr[i] + op_size(i_load_op[i]);

            // Two ranges overlap exactly when one of them starts inside the other
            load_in_store[i] = (i_load_addr[i] >= i_store_addr) &&
                               (i_load_addr[i] < store_end);
            store_in_load[i] = (i_store_addr >= i_load_addr[i]) &&
                               (i_store_addr < load_end[i]);

            // Slot state is not checked here, the queue decides which flags matter
            o_hit[i] = i_store_en & (load_in_store[i] | store_in_load[i]);
        end
    end

endmodule

// ==== logic/lsu_op_pkg.sv ====
// Memory-op encoding for the load/store unit, limited to byte, half and word accesses
// Addresses are plain byte addresses with no alignment rule enforced here
package lsu_op_pkg;

    // Every op code fits in this many bits
    localparam int LSU_OP_WIDTH = 4;

    // Byte address width used by loads and stores alike
    localparam int ADDR_WIDTH = 32;

    // Loads come first, then stores
    // The U forms zero-extend, which only matters once data is tracked
    typedef enum logic [LSU_OP_WIDTH-1:0] {
        LSU_OP_LB  = 4'd0,
        LSU_OP_LH  = 4'd1,
        LSU_OP_LW  = 4'd2,
        LSU_OP_LBU = 4'd3,
        LSU_OP_LHU = 4'd4,
        LSU_OP_SB  = 4'd5,
        LSU_OP_SH  = 4'd6,
        LSU_OP_SW  = 4'd7
    } lsu_op_t;

endpackage

// ==== sim.f ====
logic/lsu_op_pkg.sv
logic/lq_cfg_pkg.sv
logic/lq_pick_first.sv
logic/lq_store_overlap.sv
logic/load_queue.sv
testbench/tb_load_queue.sv

// ==== testbench/tb_load_queue.sv ====
// Directed testbench for the load queue with a slot scoreboard and a fixed-seed LFSR
// Assumes every ROB tag is unique among occupied slots, which the tag scheme below ensures
`timescale 1ns/10ps

module tb_load_queue;

    localparam int DEPTH = lq_cfg_pkg::LQ_DEPTH;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;
    localparam int REPLAY_WAIT = 10;
    // Cycle budgets of reset and tests 1 to 6, doubled as margin
    localparam int BUDGET_CYCLES = 10 + 40 + 40 + 60 + 60 + 80 + 40;
    localparam int WATCHDOG_NS = BUDGET_CYCLES * 8 * 2;

    logic clk = 1'b0;
    logic n_rst;
    logic i_flush;
    logic o_full;
    logic i_alloc_en;
    lsu_op_pkg::lsu_op_t i_alloc_op;
    logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0] i_alloc_tag;
    logic [31:0] i_alloc_addr;
    logic [DEPTH-1:0] o_alloc_select;
    logic i_replay_stall;
    logic o_replay_en;
    logic [DEPTH-1:0] o_replay_select;
    lsu_op_pkg::lsu_op_t o_replay_op;
    logic [31:0] o_replay_addr;
    logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0] o_replay_tag;
    logic i_update_en;
    logic [DEPTH-1:0] i_update_select;
    logic i_update_retry;
    logic [lq_cfg_pkg::MHQ_TAG_WIDTH-1:0] i_update_mhq_tag;
    logic i_update_mhq_retry;
    logic i_mhq_fill_en;
    logic [lq_cfg_pkg::MHQ_TAG_WIDTH-1:0] i_mhq_fill_tag;
    logic i_store_retire_en;
    logic [31:0] i_store_retire_addr;
    lsu_op_pkg::lsu_op_t i_store_retire_op;
    logic i_rob_retire_en;
    logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0] i_rob_retire_tag;
    logic o_rob_retire_ack;
    logic o_rob_retire_misspec;

    // Scoreboard, one entry per slot index
    logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0] sb_tag [DEPTH];
    logic [31:0] sb_addr [DEPTH];
    lsu_op_pkg::lsu_op_t sb_op [DEPTH];
    bit sb_valid [DEPTH];
    bit sb_done [DEPTH];
    bit sb_misspec [DEPTH];

    logic [15:0] lfsr_q = 16'd37;
    int errors = 0;
    int tests_run = 0;
    int errors_at_start = 0;

    always #4 clk = ~clk;

    load_queue u_load_queue (.*);

    // A replay always names exactly one slot
    assert property (@(posedge clk) disable iff (!n_rst) o_replay_en |-> $onehot(o_replay_select))
    else begin
        errors++;
        $display("Replay was signalled without a single slot selected at %0t", $time);
    end

    // One LFSR step per bit taken, newest bit lands in bit 0
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic b;
        v = '0;
        for (int k = 0; k < n; k++) begin
            b = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (b) begin
                lfsr_q = lfsr_q ^ LFSR_TAPS;
            end
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic int access_bytes(input lsu_op_pkg::lsu_op_t op);
        case (op)
            lsu_op_pkg::LSU_OP_LB, lsu_op_pkg::LSU_OP_LBU, lsu_op_pkg::LSU_OP_SB: return 1;
            lsu_op_pkg::LSU_OP_LH, lsu_op_pkg::LSU_OP_LHU, lsu_op_pkg::LSU_OP_SH: return 2;
            default: return 4;
        endcase
    endfunction

    // Half-open ranges meet when each one starts before the other ends
    function automatic bit ranges_meet(input logic [31:0] a_addr, input lsu_op_pkg::lsu_op_t a_op,
                                       input logic [31:0] b_addr, input lsu_op_pkg::lsu_op_t b_op);
        longint a_end;
        longint b_end;
        a_end = longint'(a_addr) + access_bytes(a_op);
        b_end = longint'(b_addr) + access_bytes(b_op);
        return (longint'(a_addr) < b_end) && (longint'(b_addr) < a_end);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("Test %0d %s: %s", tests_run, name,
                 (errors == errors_at_start) ? "pass" : "FAIL");
        errors_at_start = errors;
    endtask

    // Expected slot is the lowest free one, or none when the model is full
    task automatic alloc_load(input lsu_op_pkg::lsu_op_t op, input logic [31:0] addr);
        int slot;
        int free_left;
        logic [31:0] r;
        logic [lq_cfg_pkg::ROB_TAG_WIDTH-1:0] tag;
        logic [DEPTH-1:0] exp_sel;
        slot = -1;
        free_left = 0;
        for (int k = DEPTH - 1; k >= 0; k--) begin
            if (!sb_valid[k]) begin
                slot = k;
                free_left++;
            end
        end
        if (slot >= 0) begin
            free_left--;
        end
        r = rand_bits(2);
        tag = {r[1:0], 3'(slot)};
        exp_sel = (slot >= 0) ? (DEPTH'(1) << slot) : '0;
        @(posedge clk);
        i_alloc_en <= 1'b1;
        i_alloc_op <= op;
        i_alloc_tag <= tag;
        i_alloc_addr <= addr;
        @(negedge clk);
        check_eq("o_full", 32'(free_left == 0), 32'(o_full));
        @(posedge clk);
        i_alloc_en <= 1'b0;
        @(negedge clk);
        check_eq("o_alloc_select", 32'(exp_sel), 32'(o_alloc_select));
        if (slot >= 0) begin
            sb_valid[slot] = 1'b1;
            sb_done[slot] = 1'b0;
            sb_misspec[slot] = 1'b0;
            sb_tag[slot] = tag;
            sb_addr[slot] = addr;
            sb_op[slot] = op;
        end
    endtask

    task automatic update_slot(input int slot, input logic retry, input logic mhq_retry,
                               input logic [lq_cfg_pkg::MHQ_TAG_WIDTH-1:0] mhq_tag);
        @(posedge clk);
        i_update_en <= 1'b1;
        i_update_select <= DEPTH'(1) << slot;
        i_update_retry <= retry;
        i_update_mhq_retry <= mhq_retry;
        i_update_mhq_tag <= mhq_tag;
        @(posedge clk);
        i_update_en <= 1'b0;
        sb_done[slot] = !retry;
        // A waiting load reads memory again, so no earlier store sticks
        if (retry) begin
            sb_misspec[slot] = 1'b0;
        end
    endtask

    task automatic fill(input logic [lq_cfg_pkg::MHQ_TAG_WIDTH-1:0] tag);
        @(posedge clk);
        i_mhq_fill_en <= 1'b1;
        i_mhq_fill_tag <= tag;
        @(posedge clk);
        i_mhq_fill_en <= 1'b0;
    endtask

    task automatic store_retire(input lsu_op_pkg::lsu_op_t op, input logic [31:0] addr);
        @(posedge clk);
        i_store_retire_en <= 1'b1;
        i_store_retire_op <= op;
        i_store_retire_addr <= addr;
        @(posedge clk);
        i_store_retire_en <= 1'b0;
        for (int k = 0; k < DEPTH; k++) begin
            if (sb_valid[k] && ranges_meet(addr, op, sb_addr[k], sb_op[k])) begin
                sb_misspec[k] = 1'b1;
            end
        end
    endtask

    // Any occupied slot is freed, but only a DONE one is acknowledged
    task automatic retire_load(input int slot);
        @(posedge clk);
        i_rob_retire_en <= 1'b1;
        i_rob_retire_tag <= sb_tag[slot];
        @(posedge clk);
        i_rob_retire_en <= 1'b0;
        @(negedge clk);
        check_eq("o_rob_retire_ack", 32'(sb_done[slot]), 32'(o_rob_retire_ack));
        if (sb_done[slot]) begin
            check_eq("o_rob_retire_misspec", 32'(sb_misspec[slot]), 32'(o_rob_retire_misspec));
        end
        sb_valid[slot] = 1'b0;
        sb_done[slot] = 1'b0;
    endtask

    task automatic expect_no_replay(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_eq("o_replay_en", 32'(0), 32'(o_replay_en));
        end
    endtask

    task automatic wait_replay();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!o_replay_en && waited < REPLAY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (o_replay_en)
        else begin
            errors++;
            $display("No replay came out within %0d cycles at %0t", REPLAY_WAIT, $time);
        end
    endtask

    task automatic check_replay(input int slot);
        check_eq("o_replay_en", 32'(1), 32'(o_replay_en));
        check_eq("o_replay_select", 32'(DEPTH'(1) << slot), 32'(o_replay_select));
        check_eq("o_replay_op", 32'(sb_op[slot]), 32'(o_replay_op));
        check_eq("o_replay_addr", sb_addr[slot], o_replay_addr);
        check_eq("o_replay_tag", 32'(sb_tag[slot]), 32'(o_replay_tag));
    endtask

    initial begin
        n_rst <= 1'b0;
        i_flush <= 1'b0;
        i_alloc_en <= 1'b0;
        i_alloc_op <= lsu_op_pkg::LSU_OP_LW;
        i_alloc_tag <= '0;
        i_alloc_addr <= '0;
        i_replay_stall <= 1'b0;
        i_update_en <= 1'b0;
        i_update_select <= '0;
        i_update_retry <= 1'b0;
        i_update_mhq_tag <= '0;
        i_update_mhq_retry <= 1'b0;
        i_mhq_fill_en <= 1'b0;
        i_mhq_fill_tag <= '0;
        i_store_retire_en <= 1'b0;
        i_store_retire_addr <= '0;
        i_store_retire_op <= lsu_op_pkg::LSU_OP_SB;
        i_rob_retire_en <= 1'b0;
        i_rob_retire_tag <= '0;
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        check_eq("o_replay_en", 32'(0), 32'(o_replay_en));
        check_eq("o_rob_retire_ack", 32'(0), 32'(o_rob_retire_ack));
        end_test("reset");

        // Eight loads fill slots 0 to 7, then a ninth is refused
        repeat (9) begin
            alloc_load(lsu_op_pkg::LSU_OP_LW, 32'h1000_0000 | (rand_bits(12) << 4));
        end
        end_test("allocate until full");

        retire_load(5);
        update_slot(3, 1'b0, 1'b0, 2'd0);
        retire_load(3);
        alloc_load(lsu_op_pkg::LSU_OP_LH, 32'h1000_0000 | (rand_bits(12) << 4));
        alloc_load(lsu_op_pkg::LSU_OP_LBU, 32'h1000_0000 | (rand_bits(12) << 4));
        end_test("complete and retire");

        update_slot(1, 1'b1, 1'b0, 2'd2);
        expect_no_replay(3);
        fill(2'd1);
        expect_no_replay(3);
        // Park the woken slot behind a stall, then let one launch through
        @(posedge clk);
        i_replay_stall <= 1'b1;
        fill(2'd2);
        expect_no_replay(3);
        @(posedge clk);
        i_replay_stall <= 1'b0;
        @(posedge clk);
        i_replay_stall <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_replay(1);
        end
        @(posedge clk);
        i_replay_stall <= 1'b0;
        @(posedge clk);
        expect_no_replay(2);
        end_test("tag wait and replay");

        update_slot(2, 1'b1, 1'b1, 2'd0);
        update_slot(4, 1'b1, 1'b1, 2'd1);
        expect_no_replay(2);
        fill(2'd3);
        wait_replay();
        check_replay(2);
        wait_replay();
        check_replay(4);
        end_test("fill wait order");

        retire_load(6);
        alloc_load(lsu_op_pkg::LSU_OP_LW, 32'h0000_2000);
        update_slot(6, 1'b0, 1'b0, 2'd0);
        store_retire(lsu_op_pkg::LSU_OP_SB, 32'h0000_2003);
        retire_load(6);
        // Stores just outside the word on both sides
        alloc_load(lsu_op_pkg::LSU_OP_LW, 32'h0000_2000);
        update_slot(6, 1'b0, 1'b0, 2'd0);
        store_retire(lsu_op_pkg::LSU_OP_SB, 32'h0000_2004);
        store_retire(lsu_op_pkg::LSU_OP_SW, 32'h0000_1FFC);
        store_retire(lsu_op_pkg::LSU_OP_SH, 32'h0000_1FFE);
        retire_load(6);
        alloc_load(lsu_op_pkg::LSU_OP_LBU, 32'h0000_2002);
        update_slot(6, 1'b0, 1'b0, 2'd0);
        store_retire(lsu_op_pkg::LSU_OP_SW, 32'h0000_2000);
        retire_load(6);
        end_test("store overlap");

        // Take the last free slot so the queue is full going into the flush
        alloc_load(lsu_op_pkg::LSU_OP_LW, 32'h1000_0000 | (rand_bits(12) << 4));
        update_slot(5, 1'b1, 1'b1, 2'd0);
        @(posedge clk);
        i_replay_stall <= 1'b1;
        fill(2'd0);
        @(posedge clk);
        i_replay_stall <= 1'b0;
        @(posedge clk);
        i_replay_stall <= 1'b1;
        @(negedge clk);
        check_replay(5);
        // The stall holds the replay, so only the flush can drop it
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        i_replay_stall <= 1'b0;
        @(negedge clk);
        check_eq("o_replay_en", 32'(0), 32'(o_replay_en));
        check_eq("o_full", 32'(0), 32'(o_full));
        for (int k = 0; k < DEPTH; k++) begin
            sb_valid[k] = 1'b0;
        end
        alloc_load(lsu_op_pkg::LSU_OP_LW, 32'h1000_0000 | (rand_bits(12) << 4));
        end_test("flush");

        $display("Summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule
